// ==== test/pool_input.txt ====
# name op win_log2 windows base seed step stall_percent write_count first_word
# op 2 is max and 3 is average, base seed step first_word in hex, the rest decimal
# Max pooling over 2, 4 and 8 bursts with mixed signs
max_w2    2 1 3 0000 1000 1357  0 24 1000
max_w4    2 2 2 0100 d000 0123  0 16 0e48
max_w8    2 3 1 0040 7000 0031  0  8 7f50
# Average pooling, negative and mixed sums
ave_w2    3 1 4 0200 0010 fff3  0 32 e5dc
ave_w4    3 2 2 0000 ff00 0021  0 16 008c
ave_w8    3 3 1 0300 4000 0400  0  8 f000
# Window of one burst passes samples through
win1_max  2 0 2 00a0 1234 0101  0 16 b2d4
win1_ave  3 0 2 01f0 8765 0011  0 16 a855
# Random stalls on i_engine_valid
stall_max 2 2 3 0400 3000 0777 40 24 47b8
stall_ave 3 1 4 1000 c000 0013 60 32 f04c
stall_a8  3 3 2 1e00 0100 0f0f 25 16 e8a4

// ==== compile.f ====
+incdir+include
logic/pool_pkg.sv
logic/pool_ctrl.sv
logic/burst_deser.sv
logic/window_reducer.sv
logic/wb_serializer.sv
logic/pool_engine.sv
test/tb_pool_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pooling engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_pool_engine -f compile.f

rm -f sim.log
./obj_dir/Vtb_pool_engine | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

// ==== test/tb_pool_engine.sv ====
`include "pool_consts.svh"

module tb_pool_engine;
	timeunit 1ns;
	timeprecision 1ps;
	import pool_pkg::*;

	logic      clk = 1'b0;
	logic      rst = 1'b1;
	logic      i_start = 1'b0;
	op_t       i_op = '0;
	win_log2_t i_win_log2 = '0;
	count_t    i_num_windows = '0;
	addr_t     i_base_addr = '0;
	logic      i_engine_valid = 1'b0;
	word_t     i_rd_data = '0;
	logic      o_rd_en, o_wr_en, o_layer_finish, o_engine_ready;
	addr_t     o_rd_addr;
	word_t     o_wr_data;
	logic [31:0] o_timer;

	// Test table, one entry per data line
	string t_name[$];
	int t_op[$], t_wlog[$], t_nwin[$], t_base[$], t_seed[$];
	int t_step[$], t_stall[$], t_count[$], t_first[$];

	logic [15:0] cur_seed = '0;  // Memory pattern of the running job
	logic [15:0] cur_step = '0;
	logic [15:0] cur_first = '0;
	int          cur_stall = 0;   // Percent of cycles with i_engine_valid low
	logic [15:0] exp_q[$];        // Expected write words in bus order
	logic [15:0] exp_word;
	int exp_addr = 0;
	int rd_count = 0;
	int wr_count = 0;
	int finish_count = 0;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int tests_run = 0;
	int tests_failed = 0;

	pool_engine u_dut (.*);

	always #10 clk = ~clk; // 20 ns period

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
			errors++;
		end
	endtask

	// Memory contents, low 16 bits of seed plus address times step
	function automatic word_t mem_word(input int addr, input logic [15:0] seed,
			input logic [15:0] step);
		logic [31:0] val;
		val = 32'(seed) + 32'(addr) * 32'(step);
		return val[15:0];
	endfunction

	// One channel of one window, bursts sit eight addresses apart
	function automatic logic [15:0] reduce_channel(input int op, input int wlog,
			input int first_addr, input logic [15:0] seed, input logic [15:0] step);
		int acc;
		int v;
		int b;
		acc = 0;
		for (b = 0; b < (1 << wlog); b++) begin
			v = int'(mem_word(first_addr + b * `POOL_BURST_LEN, seed, step)); // Sign extends
			if (b == 0)
				acc = v;
			else if (op == `POOL_OP_MAX)
				acc = (v > acc) ? v : acc; // Signed max
			else
				acc = acc + v;
		end
		if (op == `POOL_OP_AVE)
			acc = acc >>> wlog; // Floor of the mean
		return acc[15:0];
	endfunction

	// Memory model, address check and write check
	always @(posedge clk) begin
		if (o_rd_en) begin
			compare("o_rd_addr", exp_addr, 32'(o_rd_addr)); // Contiguous from the base
			exp_addr++;
			rd_count++;
			i_rd_data <= mem_word(32'(o_rd_addr), cur_seed, cur_step); // Next cycle
		end
		if (o_wr_en) begin
			if (wr_count == 0)
				compare("first o_wr_data", 32'(cur_first), {16'h0, o_wr_data});
			if (exp_q.size() == 0) begin
				$display("Write of %h arrived with no result left to write", o_wr_data);
				errors++;
			end else begin
				exp_word = exp_q.pop_front();
				compare("o_wr_data", 32'(exp_word), {16'h0, o_wr_data});
			end
			wr_count++;
		end
		if (o_layer_finish)
			finish_count++;
	end

	// Random read stalls
	always @(posedge clk)
		i_engine_valid <= (cur_stall == 0) || (($urandom % 100) >= 32'(cur_stall));

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, a job never reached o_layer_finish", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic load_tests;
		int fd;
		int n;
		int f[9];
		string line;
		string name;
		fd = $fopen("test/pool_input.txt", "r");
		if (fd == 0)
			return;
		cycle_limit = 10; // Reset phase
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %d %d %d %h %h %h %d %d %h", name,
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
			if (n != 10)
				continue;
			t_name.push_back(name);
			t_op.push_back(f[0]);
			t_wlog.push_back(f[1]);
			t_nwin.push_back(f[2]);
			t_base.push_back(f[3]);
			t_seed.push_back(f[4]);
			t_step.push_back(f[5]);
			t_stall.push_back(f[6]);
			t_count.push_back(f[7]);
			t_first.push_back(f[8]);
			// Reads stretched by the stall rate, plus slack per job
			cycle_limit += ((f[2] << (f[1] + 3)) * 100) / (100 - f[6]) + 50;
		end
		$fclose(fd);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("%s: ok, %0d writes", name, wr_count);
		else begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic run_test(input int t);
		int len;
		int reads;
		int errs_before;
		int w;
		int c;
		len = 1 << t_wlog[t];
		reads = t_nwin[t] * len * `POOL_BURST_LEN;
		errs_before = errors;
		exp_q.delete();
		for (w = 0; w < t_nwin[t]; w++)
			for (c = 0; c < `POOL_BURST_LEN; c++)
				exp_q.push_back(reduce_channel(t_op[t], t_wlog[t],
					t_base[t] + w * len * `POOL_BURST_LEN + c, t_seed[t][15:0], t_step[t][15:0]));
		compare("model first word", t_first[t], 32'(exp_q[0])); // Data file against model
		cur_seed = t_seed[t][15:0];
		cur_step = t_step[t][15:0];
		cur_first = t_first[t][15:0];
		cur_stall = t_stall[t];
		exp_addr = t_base[t];
		rd_count = 0;
		wr_count = 0;
		finish_count = 0;
		i_start <= 1'b1;
		i_op <= op_t'(t_op[t]);
		i_win_log2 <= win_log2_t'(t_wlog[t]);
		i_num_windows <= count_t'(t_nwin[t]);
		i_base_addr <= addr_t'(t_base[t]);
		@(posedge clk);
		i_start <= 1'b0;
		do begin
			@(posedge clk);
			if (!o_layer_finish)
				compare("o_engine_ready", 0, 32'(o_engine_ready)); // Low inside the job
		end while (!o_layer_finish);
		compare("o_engine_ready", 1, 32'(o_engine_ready));
		compare("read count", reads, rd_count);
		compare("write count", t_count[t], wr_count);
		compare("write count", t_nwin[t] * `POOL_BURST_LEN, wr_count);
		if (exp_q.size() != 0) begin
			$display("%0d results still unwritten at o_layer_finish", exp_q.size());
			errors++;
		end
		if (o_timer < 32'(reads)) begin
			$display("o_timer %0d is below the read total %0d", o_timer, reads);
			errors++;
		end
		@(posedge clk);
		compare("o_layer_finish", 0, 32'(o_layer_finish)); // Single cycle pulse
		compare("o_layer_finish pulses", 1, finish_count);
		report_test(t_name[t], errs_before);
	endtask

	initial begin
		void'($urandom(32'hdcaa));
		load_tests();
		if (t_name.size() == 0) begin
			$display("No tests could be read from test/pool_input.txt");
			errors++;
		end else begin
			repeat (4) @(posedge clk);
			rst <= 1'b0;
			@(posedge clk);
			compare("o_rd_en", 0, 32'(o_rd_en));
			compare("o_wr_en", 0, 32'(o_wr_en));
			compare("o_layer_finish", 0, 32'(o_layer_finish));
			compare("o_engine_ready", 1, 32'(o_engine_ready));
			compare("o_timer", 0, o_timer);
			report_test("reset_state", 0);
			foreach (t_name[t])
				run_test(t); // Back to back jobs
		end
		$display("Tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== logic/pool_engine.sv ====
module pool_engine (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_start,
	input  pool_pkg::op_t       i_op,
	input  pool_pkg::win_log2_t i_win_log2,
	input  pool_pkg::count_t    i_num_windows,
	input  pool_pkg::addr_t     i_base_addr,
	input  logic                i_engine_valid,
	input  pool_pkg::word_t     i_rd_data,
	output logic                o_rd_en,
	output pool_pkg::addr_t     o_rd_addr,
	output logic                o_wr_en,
	output pool_pkg::word_t     o_wr_data,
	output logic                o_layer_finish,
	output logic                o_engine_ready,
	output logic [31:0]         o_timer
);
	import pool_pkg::*;

	op_t       op;            // Held job op
	win_log2_t win_log2;
	logic      burst_valid;
	burst_t    burst;
	logic      result_valid;
	burst_t    result;
	logic      wb_done;

	// Job control and read side
	pool_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.i_start        (i_start),
		.i_op           (i_op),
		.i_win_log2     (i_win_log2),
		.i_num_windows  (i_num_windows),
		.i_base_addr    (i_base_addr),
		.i_engine_valid (i_engine_valid),
		.i_wb_done      (wb_done),
		.o_rd_en        (o_rd_en),
		.o_rd_addr      (o_rd_addr),
		.o_op           (op),
		.o_win_log2     (win_log2),
		.o_layer_finish (o_layer_finish),
		.o_engine_ready (o_engine_ready),
		.o_timer        (o_timer)
	);

	burst_deser u_deser (
		.clk           (clk),
		.rst           (rst),
		.i_rd_en       (o_rd_en),     // Same strobe the memory sees
		.i_rd_data     (i_rd_data),
		.o_burst_valid (burst_valid),
		.o_burst       (burst)
	);

	window_reducer u_reduce (
		.clk            (clk),
		.rst            (rst),
		.i_op           (op),
		.i_win_log2     (win_log2),
		.i_burst_valid  (burst_valid),
		.i_burst        (burst),
		.o_result_valid (result_valid),
		.o_result       (result)
	);

	// Write side, no back-pressure
	wb_serializer u_wb (
		.clk            (clk),
		.rst            (rst),
		.i_result_valid (result_valid),
		.i_result       (result),
		.o_wr_en        (o_wr_en),
		.o_wr_data      (o_wr_data),
		.o_wb_done      (wb_done)
	);

endmodule

// ==== logic/wb_serializer.sv ====
`include "pool_consts.svh"

module wb_serializer (
	input  logic             clk,
	input  logic             rst,
	input  logic             i_result_valid,  // One pulse per window
	input  pool_pkg::burst_t i_result,
	output logic             o_wr_en,
	output pool_pkg::word_t  o_wr_data,
	output logic             o_wb_done        // With the channel 7 write
);
	import pool_pkg::*;

	localparam int IDX_W = $clog2(`POOL_BURST_LEN);

	burst_t           held;    // Result being written out
	logic [IDX_W-1:0] idx;     // Channel on the bus this cycle
	logic             active;
	logic             idx_last;

	assign idx_last = (idx == IDX_W'(`POOL_BURST_LEN - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			idx    <= '0;
		end else begin
			if (i_result_valid) begin
				active <= 1'b1; // First write in the next cycle
				idx    <= '0;
			end else if (active) begin
				idx <= idx + 1'b1;
				if (idx_last)
					active <= 1'b0;
			end
		end
	end

	// Next result is always at least eight cycles away
	always_ff @(posedge clk) begin
		if (i_result_valid)
			held <= i_result;
	end

	// Lowest channel first
	assign o_wr_en   = active;
	assign o_wr_data = held[idx*`POOL_DATA_W +: `POOL_DATA_W];
	assign o_wb_done = active && idx_last;

endmodule

// ==== logic/window_reducer.sv ====
`include "pool_consts.svh"

module window_reducer (
	input  logic                clk,
	input  logic                rst,
	input  pool_pkg::op_t       i_op,          // Latched job op
	input  pool_pkg::win_log2_t i_win_log2,    // Latched window log
	input  logic                i_burst_valid,
	input  pool_pkg::burst_t    i_burst,
	output logic                o_result_valid, // One cycle per window
	output pool_pkg::burst_t    o_result
);
	import pool_pkg::*;

	localparam int W       = `POOL_DATA_W;
	localparam int BCNT_W  = `POOL_MAX_WIN_LOG2;

	logic [BCNT_W-1:0] bcnt;      // Burst index inside the window
	logic [BCNT_W-1:0] last_idx;  // Window length minus one
	logic              first;
	logic              last;
	logic              is_max;
	logic              is_ave;

	assign last_idx = ~({BCNT_W{1'b1}} << i_win_log2);
	assign first    = (bcnt == '0);
	assign last     = (bcnt == last_idx); // Window of one burst is first and last at once
	assign is_max   = (i_op == `POOL_OP_W'(`POOL_OP_MAX));
	assign is_ave   = (i_op == `POOL_OP_W'(`POOL_OP_AVE));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bcnt           <= '0;
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= i_burst_valid && last;
			if (i_burst_valid) begin
				if (last)
					bcnt <= '0;
				else
					bcnt <= bcnt + 1'b1;
			end
		end
	end

	for (genvar c = 0; c < `POOL_BURST_LEN; c++) begin : g_lane
		word_t sample;
		sum_t  ext;      // Sample widened to accumulator size
		sum_t  lane;     // Running max or sum of this channel
		sum_t  nxt;
		sum_t  shifted;
		word_t res;

		assign sample = i_burst[c*W +: W];
		assign ext    = sum_t'(sample); // Sign extends

		always_comb begin
			if (first)
				nxt = ext; // New window starts from the sample itself
			else if (is_max)
				nxt = (ext > lane) ? ext : lane;
			else
				nxt = lane + ext;
		end

		// Floor of the mean, negative sums round toward minus infinity
		assign shifted = nxt >>> i_win_log2;

		always_ff @(posedge clk) begin
			if (i_burst_valid)
				lane <= nxt;
			if (i_burst_valid && last)
				res <= is_ave ? shifted[W-1:0] : nxt[W-1:0];
		end

		assign o_result[c*W +: W] = res;
	end

endmodule

// ==== logic/burst_deser.sv ====
`include "pool_consts.svh"

module burst_deser (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_rd_en,        // Read strobe toward memory
	input  pool_pkg::word_t   i_rd_data,      // Valid one cycle after i_rd_en
	output logic              o_burst_valid,  // One cycle per full burst
	output pool_pkg::burst_t  o_burst
);

	localparam int CNT_W = $clog2(`POOL_BURST_LEN);
	localparam int TOP   = `POOL_BURST_LEN * `POOL_DATA_W - 1;

	logic             rd_valid;  // Delayed strobe, marks returned data
	logic [CNT_W-1:0] word_cnt;  // Words already in the current burst
	logic             burst_last;

	assign burst_last = (word_cnt == CNT_W'(`POOL_BURST_LEN - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_valid      <= 1'b0;
			word_cnt      <= '0;
			o_burst_valid <= 1'b0;
		end else begin
			rd_valid      <= i_rd_en; // Fixed one cycle memory latency
			o_burst_valid <= rd_valid && burst_last;
			if (rd_valid) begin
				if (burst_last)
					word_cnt <= '0;
				else
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// New word enters at the top and walks down
	// after eight words the first one sits in channel 0
	always_ff @(posedge clk) begin
		if (rd_valid)
			o_burst <= {i_rd_data, o_burst[TOP:`POOL_DATA_W]};
	end

endmodule

// ==== logic/pool_ctrl.sv ====
`include "pool_consts.svh"

module pool_ctrl (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_start,        // One cycle, looked at only in IDLE
	input  pool_pkg::op_t      i_op,
	input  pool_pkg::win_log2_t i_win_log2,
	input  pool_pkg::count_t   i_num_windows,  // At least one
	input  pool_pkg::addr_t    i_base_addr,
	input  logic               i_engine_valid, // Level, reads only while high
	input  logic               i_wb_done,      // One pulse per written window
	output logic               o_rd_en,
	output pool_pkg::addr_t    o_rd_addr,
	output pool_pkg::op_t      o_op,
	output pool_pkg::win_log2_t o_win_log2,
	output logic               o_layer_finish,
	output logic               o_engine_ready,
	output logic [31:0]        o_timer
);
	import pool_pkg::*;

	localparam int BURST_LOG2 = $clog2(`POOL_BURST_LEN);
	// Reads per job: windows times window length times burst length
	localparam int RD_CNT_W = `POOL_COUNT_W + `POOL_MAX_WIN_LOG2 + BURST_LOG2;

	typedef enum logic [1:0] {
		IDLE,   // Waiting for start
		BUSY,   // Issuing reads
		DRAIN,  // All reads out, waiting for the last write back
		FINISH  // Single cycle, layer finish
	} ctrl_state_e;

	ctrl_state_e state;

	count_t num_windows;   // Latched job length
	count_t done_count;    // Windows written back so far

	logic [RD_CNT_W-1:0] rd_total;
	logic [RD_CNT_W-1:0] rd_count;

	logic issue;
	logic last_read;
	logic last_done;

	assign issue     = (state == BUSY) && i_engine_valid;
	assign last_read = issue && (rd_count == rd_total - 1'b1);
	assign last_done = i_wb_done && (done_count == num_windows - 1'b1);

	// Job settings held for the whole job
	always_ff @(posedge clk) begin
		if (state == IDLE && i_start) begin
			o_op        <= i_op;
			o_win_log2  <= i_win_log2;
			num_windows <= i_num_windows;
			rd_total    <= RD_CNT_W'(i_num_windows) << (i_win_log2 + BURST_LOG2);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state      <= IDLE;
			o_rd_en    <= 1'b0;
			o_rd_addr  <= '0;
			rd_count   <= '0;
			done_count <= '0;
			o_timer    <= '0;
		end else begin
			o_rd_en <= issue; // Data comes back one cycle after the strobe
			if (o_rd_en)
				o_rd_addr <= o_rd_addr + 1'b1; // Step past the word just read
			if (issue)
				rd_count <= rd_count + 1'b1;
			if (i_wb_done)
				done_count <= done_count + 1'b1;
			if (state == BUSY || state == DRAIN)
				o_timer <= o_timer + 32'd1;

			case (state)
				IDLE: begin
					if (i_start) begin
						state      <= BUSY;
						o_rd_addr  <= i_base_addr;
						rd_count   <= '0;
						done_count <= '0;
						o_timer    <= '0; // Fresh count per job
					end
				end
				BUSY: begin
					if (last_read)
						state <= DRAIN;
				end
				DRAIN: begin
					// Deser, reducer and serializer still busy with the tail
					if (last_done)
						state <= FINISH;
				end
				FINISH: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign o_layer_finish = (state == FINISH);
	assign o_engine_ready = (state == FINISH) || (state == IDLE); // Low only inside a job

endmodule

// ==== logic/pool_pkg.sv ====
`include "pool_consts.svh"

package pool_pkg;

	// One channel sample, two's complement
	typedef logic signed [`POOL_DATA_W-1:0] word_t;

	// Eight samples side by side
	// channel 0 sits in the low bits
	typedef logic [`POOL_BURST_LEN*`POOL_DATA_W-1:0] burst_t;

	// Per channel accumulator, wide enough for a full 8 burst sum
	typedef logic signed [`POOL_SUM_W-1:0] sum_t;

	typedef logic [`POOL_ADDR_W-1:0] addr_t; // Read address into data memory

	typedef logic [`POOL_COUNT_W-1:0] count_t; // Window count and window index

	// Log2 of the window length in bursts
	typedef logic [`POOL_WIN_LOG2_W-1:0] win_log2_t;

	typedef logic [`POOL_OP_W-1:0] op_t; // Max or average pooling

endpackage

// ==== include/pool_consts.svh ====
`ifndef POOL_CONSTS_SVH
`define POOL_CONSTS_SVH

// Burst geometry
`define POOL_BURST_LEN    8   // Channels per burst
`define POOL_DATA_W       16  // Sample word width

// Memory side
`define POOL_ADDR_W       13  // Data memory read address

// Window lengths of 1, 2, 4 or 8 bursts
`define POOL_MAX_WIN_LOG2 3
`define POOL_WIN_LOG2_W   2
`define POOL_SUM_W        19  // Word plus growth of an 8 burst sum
`define POOL_COUNT_W      16  // Windows per job

// Op codes
`define POOL_OP_W         3
`define POOL_OP_MAX       2
`define POOL_OP_AVE       3

`endif
